// ==== hw/approxMulPkg.sv ====
`default_nettype none

package approxMulPkg;

    localparam int opWidth   = 16;
    localparam int mantWidth = 8;
    localparam int resWidth  = 32;
    localparam int numPairs  = 8;
    localparam int addrWidth = 3;
    localparam int maxShift  = 15;
    localparam int cntWidth  = $clog2(maxShift + 1);

    // Controller state codes.
    localparam int stateWidth = 4;
    localparam logic [stateWidth-1:0] stIdle      = 4'd0;
    localparam logic [stateWidth-1:0] stInit      = 4'd1;
    localparam logic [stateWidth-1:0] stShCntClr  = 4'd2;
    localparam logic [stateWidth-1:0] stLoadOps   = 4'd3;
    localparam logic [stateWidth-1:0] stCheck     = 4'd4;
    localparam logic [stateWidth-1:0] stShiftBoth = 4'd5;
    localparam logic [stateWidth-1:0] stShiftA    = 4'd6;
    localparam logic [stateWidth-1:0] stShiftB    = 4'd7;
    localparam logic [stateWidth-1:0] stMultiply  = 4'd8;
    localparam logic [stateWidth-1:0] stCheckA    = 4'd9;
    localparam logic [stateWidth-1:0] stShiftRA   = 4'd10;
    localparam logic [stateWidth-1:0] stCheckB    = 4'd11;
    localparam logic [stateWidth-1:0] stShiftRB   = 4'd12;
    localparam logic [stateWidth-1:0] stWrite     = 4'd13;
    localparam logic [stateWidth-1:0] stDone      = 4'd14;

    // One memory word, seen raw on load and as two operands in the datapath.
    typedef union packed {
        logic [2*opWidth-1:0] raw;
        struct packed {
            logic [opWidth-1:0] opA;
            logic [opWidth-1:0] opB;
        } ops;
    } opPair_u;

endpackage

`default_nettype wire

// ==== hw/mulCtrlIf.sv ====
`default_nettype none
`timescale 1ns/1ps

interface mulCtrlIf;

    // Strobes from the controller.
    logic rdAddrRst;
    logic wrAddrRst;
    logic shCntRst;
    logic ldA;
    logic ldB;
    logic ldProd;
    logic shlA;
    logic shlB;
    logic shrRes;
    logic rdAddrInc;
    logic we;

    // Status from the datapath.
    logic msbA;
    logic msbB;
    logic normDoneA;
    logic normDoneB;
    logic cntZeroA;
    logic cntZeroB;
    logic lastPair;

    modport ctrl (
        output rdAddrRst, wrAddrRst, shCntRst, ldA, ldB, ldProd,
        output shlA, shlB, shrRes, rdAddrInc, we,
        input  msbA, msbB, normDoneA, normDoneB, cntZeroA, cntZeroB, lastPair
    );

    modport dp (
        input  rdAddrRst, wrAddrRst, shCntRst, ldA, ldB, ldProd,
        input  shlA, shlB, shrRes, rdAddrInc, we,
        output msbA, msbB, normDoneA, normDoneB, cntZeroA, cntZeroB, lastPair
    );

endinterface

`default_nettype wire

// ==== hw/opMem.sv ====
`default_nettype none
`timescale 1ns/1ps

module opMem (
    input  logic                                clk,
    input  logic                                loadEn,
    input  logic [approxMulPkg::addrWidth-1:0]  loadAddr,
    input  logic [2*approxMulPkg::opWidth-1:0]  loadData,
    input  logic [approxMulPkg::addrWidth-1:0]  rdAddr,
    output approxMulPkg::opPair_u               rdData
);
    import approxMulPkg::*;

    opPair_u mem [numPairs];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr].raw <= loadData; // Loaded as a raw word.
        end
    end

    assign rdData = mem[rdAddr];

endmodule

`default_nettype wire

// ==== hw/resMem.sv ====
`default_nettype none
`timescale 1ns/1ps

module resMem (
    input  logic                                clk,
    input  logic                                we,
    input  logic [approxMulPkg::addrWidth-1:0]  wrAddr,
    input  logic [approxMulPkg::resWidth-1:0]   wrData,
    input  logic [approxMulPkg::addrWidth-1:0]  rdAddr,
    output logic [approxMulPkg::resWidth-1:0]   rdData
);
    import approxMulPkg::*;

    logic [resWidth-1:0] mem [numPairs];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wrAddr] <= wrData;
        end
    end

    assign rdData = mem[rdAddr]; // Visible the cycle after Write.

endmodule

`default_nettype wire

// ==== hw/mulCtrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module mulCtrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done,
    mulCtrlIf.ctrl bus
);
    import approxMulPkg::*;

    logic [stateWidth-1:0] state;
    logic [stateWidth-1:0] nextState;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = stIdle;
        case (state)
            stIdle:     nextState = start ? stInit : stIdle;
            stInit:     nextState = start ? stInit : stShCntClr; // Wait for start to drop.
            stShCntClr: nextState = stLoadOps;
            stLoadOps:  nextState = stCheck;
            stCheck: begin
                case ({bus.msbA, bus.msbB})
                    2'b11:   nextState = stMultiply;
                    2'b10:   nextState = stShiftB;
                    2'b01:   nextState = stShiftA;
                    default: nextState = stShiftBoth;
                endcase
            end
            stShiftBoth: begin
                case ({bus.normDoneA, bus.normDoneB})
                    2'b11:   nextState = stMultiply;
                    2'b10:   nextState = stShiftB;
                    2'b01:   nextState = stShiftA;
                    default: nextState = stShiftBoth;
                endcase
            end
            stShiftA:   nextState = bus.normDoneA ? stMultiply : stShiftA;
            stShiftB:   nextState = bus.normDoneB ? stMultiply : stShiftB;
            stMultiply: nextState = stCheckA;
            stCheckA:   nextState = bus.cntZeroA ? stCheckB : stShiftRA;
            stShiftRA:  nextState = bus.cntZeroA ? stCheckB : stShiftRA;
            stCheckB:   nextState = bus.cntZeroB ? stWrite : stShiftRB;
            stShiftRB:  nextState = bus.cntZeroB ? stWrite : stShiftRB;
            stWrite:    nextState = bus.lastPair ? stDone : stShCntClr;
            stDone:     nextState = stIdle;
            default:    nextState = stIdle;
        endcase
    end

    always_comb begin
        bus.rdAddrRst = 1'b0;
        bus.wrAddrRst = 1'b0;
        bus.shCntRst  = 1'b0;
        bus.ldA       = 1'b0;
        bus.ldB       = 1'b0;
        bus.ldProd    = 1'b0;
        bus.shlA      = 1'b0;
        bus.shlB      = 1'b0;
        bus.shrRes    = 1'b0;
        bus.rdAddrInc = 1'b0;
        bus.we        = 1'b0;
        done          = 1'b0;
        case (state)
            stInit: begin
                bus.rdAddrRst = 1'b1;
                bus.wrAddrRst = 1'b1;
            end
            stShCntClr: bus.shCntRst = 1'b1;
            stLoadOps: begin
                bus.ldA = 1'b1;
                bus.ldB = 1'b1;
            end
            stShiftBoth: begin
                bus.shlA = 1'b1;
                bus.shlB = 1'b1;
            end
            stShiftA:   bus.shlA = 1'b1;
            stShiftB:   bus.shlB = 1'b1;
            stMultiply: bus.ldProd = 1'b1;
            stShiftRA:  bus.shrRes = 1'b1; // Counter A decrements.
            stShiftRB:  bus.shrRes = 1'b1; // Counter B decrements.
            stWrite: begin
                bus.we        = 1'b1;
                bus.rdAddrInc = 1'b1;
            end
            stDone:     done = 1'b1;
            default: begin
                done = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/mulDatapath.sv ====
`default_nettype none
`timescale 1ns/1ps

module mulDatapath (
    input  logic                                clk,
    input  logic                                rst,
    mulCtrlIf.dp                                bus,
    output logic [approxMulPkg::addrWidth-1:0]  opAddr,
    input  approxMulPkg::opPair_u               opData,
    output logic                                resWe,
    output logic [approxMulPkg::addrWidth-1:0]  resWrAddr,
    output logic [approxMulPkg::resWidth-1:0]   resWrData
);
    import approxMulPkg::*;

    logic [addrWidth-1:0]   rdAddr;
    logic [addrWidth-1:0]   wrAddr;
    logic [opWidth-1:0]     regA;
    logic [opWidth-1:0]     regB;
    logic [cntWidth-1:0]    cntA;
    logic [cntWidth-1:0]    cntB;
    logic [2*mantWidth-1:0] prod;
    logic [resWidth-1:0]    resReg;
    logic                   decA;
    logic                   decB;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdAddr <= '0;
            wrAddr <= '0;
        end else begin
            if (bus.rdAddrRst) begin
                rdAddr <= '0;
            end else if (bus.rdAddrInc) begin
                rdAddr <= rdAddr + 1'b1;
            end
            if (bus.wrAddrRst) begin
                wrAddr <= '0;
            end else if (bus.we) begin
                wrAddr <= wrAddr + 1'b1;
            end
        end
    end

    // A right shift drains counter A first, then counter B.
    assign decA = bus.shrRes & (cntA != '0);
    assign decB = bus.shrRes & (cntA == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cntA <= '0;
            cntB <= '0;
        end else if (bus.shCntRst) begin
            cntA <= '0;
            cntB <= '0;
        end else begin
            if (bus.shlA) begin
                cntA <= cntA + 1'b1;
            end else if (decA) begin
                cntA <= cntA - 1'b1;
            end
            if (bus.shlB) begin
                cntB <= cntB + 1'b1;
            end else if (decB) begin
                cntB <= cntB - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.ldA) begin
            regA <= opData.ops.opA;
        end else if (bus.shlA) begin
            regA <= {regA[opWidth-2:0], 1'b0};
        end
        if (bus.ldB) begin
            regB <= opData.ops.opB;
        end else if (bus.shlB) begin
            regB <= {regB[opWidth-2:0], 1'b0};
        end
    end

    // Top bytes of the normalized operands only.
    assign prod = regA[opWidth-1 -: mantWidth] * regB[opWidth-1 -: mantWidth];

    always_ff @(posedge clk) begin
        if (bus.ldProd) begin
            resReg <= {prod, {(resWidth - 2*mantWidth){1'b0}}};
        end else if (bus.shrRes) begin
            resReg <= {1'b0, resReg[resWidth-1:1]};
        end
    end

    assign bus.msbA = regA[opWidth-1];
    assign bus.msbB = regB[opWidth-1];

    // Lookahead on the shift under way this cycle.
    assign bus.normDoneA = regA[opWidth-2] | (cntA == cntWidth'(maxShift - 1));
    assign bus.normDoneB = regB[opWidth-2] | (cntB == cntWidth'(maxShift - 1));
    assign bus.cntZeroA  = (cntA == '0) | (decA & (cntA == cntWidth'(1)));
    assign bus.cntZeroB  = (cntB == '0) | (decB & (cntB == cntWidth'(1)));
    assign bus.lastPair  = (wrAddr == addrWidth'(numPairs - 1));

    assign opAddr    = rdAddr;
    assign resWe     = bus.we;
    assign resWrAddr = wrAddr;
    assign resWrData = resReg;

endmodule

`default_nettype wire

// ==== hw/approxMul.sv ====
`default_nettype none
`timescale 1ns/1ps

module approxMul (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    output logic                                done,
    input  logic                                loadEn,
    input  logic [approxMulPkg::addrWidth-1:0]  loadAddr,
    input  logic [2*approxMulPkg::opWidth-1:0]  loadData,
    input  logic [approxMulPkg::addrWidth-1:0]  resAddr,
    output logic [approxMulPkg::resWidth-1:0]   resData
);
    import approxMulPkg::*;

    logic [addrWidth-1:0] opAddr;
    opPair_u              opData;
    logic                 resWe;
    logic [addrWidth-1:0] resWrAddr;
    logic [resWidth-1:0]  resWrData;

    mulCtrlIf ctrlBus ();

    mulCtrl u_mulCtrl (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .done  (done),
        .bus   (ctrlBus.ctrl)
    );

    mulDatapath u_mulDatapath (
        .clk       (clk),
        .rst       (rst),
        .bus       (ctrlBus.dp),
        .opAddr    (opAddr),
        .opData    (opData),
        .resWe     (resWe),
        .resWrAddr (resWrAddr),
        .resWrData (resWrData)
    );

    opMem u_opMem (
        .clk      (clk),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .rdAddr   (opAddr),
        .rdData   (opData)
    );

    resMem u_resMem (
        .clk    (clk),
        .we     (resWe),
        .wrAddr (resWrAddr),
        .wrData (resWrData),
        .rdAddr (resAddr),
        .rdData (resData)
    );

endmodule

`default_nettype wire

// ==== test/approxMul_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps

module mulCtrlAsserts (
    input logic clk,
    input logic rst,
    input logic shlA,
    input logic shrRes,
    input logic we,
    input logic done
);

    int failCount = 0;

    shiftExclusive: assert property (@(posedge clk) disable iff (rst) !(shlA && shrRes))
        else begin
            $error("shlA and shrRes are high in the same cycle");
            failCount++;
        end

    writeSingle: assert property (@(posedge clk) disable iff (rst) we |=> !we)
        else begin
            $error("we is high for more than one cycle");
            failCount++;
        end

    donePulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done is wider than one cycle");
            failCount++;
        end

endmodule

bind mulCtrl mulCtrlAsserts u_mulCtrlAsserts (
    .clk    (clk),
    .rst    (rst),
    .shlA   (bus.shlA),
    .shrRes (bus.shrRes),
    .we     (bus.we),
    .done   (done)
);

`default_nettype wire

// ==== test/approxMulTb.sv ====
`default_nettype none
`timescale 1ns/1ps

module approxMulTb;
    import approxMulPkg::*;

    localparam int numBatches   = 2;
    localparam int pairCycles   = 80; // Worst case per pair.
    localparam int timeoutLimit = numBatches * numPairs * pairCycles + 200;
    localparam int numWords     = numBatches * numPairs * 3;

    logic                 clk;
    logic                 rst;
    logic                 start;
    logic                 done;
    logic                 loadEn;
    logic [addrWidth-1:0] loadAddr;
    logic [2*opWidth-1:0] loadData;
    logic [addrWidth-1:0] resAddr;
    logic [resWidth-1:0]  resData;

    logic [31:0] cases [numWords];
    int errorCount  = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int doneCount   = 0;
    int cycleCount  = 0;
    int testErrStart;

    approxMul u_approxMul (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .done     (done),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .resAddr  (resAddr),
        .resData  (resData)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: run exceeded %0d cycles", timeoutLimit);
            $display("Result: FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!rst && done) begin
            doneCount++;
        end
    end

    // Normalize, multiply top bytes, scale back by the total shift count.
    function automatic logic [31:0] ruleProduct(input logic [15:0] a, input logic [15:0] b);
        logic [15:0] na;
        logic [15:0] nb;
        logic [15:0] p;
        int          sa;
        int          sb;
        na = a;
        nb = b;
        sa = 0;
        sb = 0;
        while (!na[15] && sa < maxShift) begin
            na = na << 1;
            sa++;
        end
        while (!nb[15] && sb < maxShift) begin
            nb = nb << 1;
            sb++;
        end
        p = na[15:8] * nb[15:8];
        return {p, 16'h0000} >> (sa + sb);
    endfunction

    function automatic logic [31:0] caseWord(input int batch, input int idx, input int col);
        return cases[(batch * numPairs + idx) * 3 + col];
    endfunction

    task automatic loadBatch(input int batch);
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < numPairs; i++) begin
            a = caseWord(batch, i, 0);
            b = caseWord(batch, i, 1);
            @(posedge clk);
            #2;
            loadEn   = 1'b1;
            loadAddr = addrWidth'(i);
            loadData = {a[15:0], b[15:0]};
        end
        @(posedge clk);
        #2;
        loadEn = 1'b0;
    endtask

    task automatic runBatch(input int holdCycles);
        bit seen;
        int n;
        @(posedge clk);
        #2;
        start = 1'b1;
        repeat (holdCycles) @(posedge clk);
        #2;
        start = 1'b0;
        seen = 1'b0;
        n = 0;
        while (!seen && n < numPairs * pairCycles) begin
            @(negedge clk);
            seen = done;
            n++;
        end
        assert (seen) else begin
            $display("No done pulse within %0d cycles after start fell", n);
            errorCount++;
        end
    endtask

    task automatic readResult(input int addr, output logic [31:0] value);
        @(posedge clk);
        #2;
        resAddr = addrWidth'(addr);
        @(negedge clk);
        value = resData;
    endtask

    task automatic checkResults(input int batch, input int first, input int last);
        logic [31:0] expected;
        logic [31:0] actual;
        for (int addr = first; addr <= last; addr++) begin
            expected = caseWord(batch, addr, 2);
            readResult(addr, actual);
            assert (actual === expected) else begin
                $display("[FAIL] %0d ns: resData[%0d] expected %h, got %h",
                         $time, addr, expected, actual);
                errorCount++;
            end
        end
    endtask

    task automatic openTest();
        testErrStart = errorCount;
    endtask

    task automatic closeTest(input string name);
        if (errorCount == testErrStart) begin
            testsPassed++;
            $display("Test %-24s ok", name);
        end else begin
            testsFailed++;
            $display("Test %-24s %0d errors", name, errorCount - testErrStart);
        end
    endtask

    initial begin
        logic [31:0] value;
        int          doneBefore;
        int          assertFails;
        clk      = 1'b0;
        rst      = 1'b1;
        start    = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        resAddr  = '0;
        $readmemh("test/approxMul_cases.txt", cases);
        for (int i = 0; i < numBatches * numPairs; i++) begin
            assert (cases[3*i+2] === ruleProduct(cases[3*i][15:0], cases[3*i+1][15:0]))
            else begin
                $display("Cases file line %0d disagrees with the product rule", i + 1);
                errorCount++;
            end
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        openTest();
        loadBatch(0);
        repeat (numPairs * pairCycles / 4) @(posedge clk); // Batch 0 would finish well within this.
        for (int i = 0; i < numPairs; i++) begin
            readResult(i, value);
            assert (value !== caseWord(0, i, 2)) else begin
                $display("resData[%0d] holds a result before any batch ran", i);
                errorCount++;
            end
        end
        assert (doneCount == 0) else begin
            $display("done pulsed after reset without a start");
            errorCount++;
        end
        closeTest("reset state");

        doneBefore = doneCount;
        runBatch(5); // Start held high for several cycles.
        openTest();
        checkResults(0, 0, 2);
        closeTest("aligned operands");
        openTest();
        checkResults(0, 3, 7);
        closeTest("mixed shift counts");
        openTest();
        assert (doneCount == doneBefore + 1) else begin
            $display("done pulsed %0d times for one batch", doneCount - doneBefore);
            errorCount++;
        end
        checkResults(0, 0, 7);
        closeTest("start held high");

        loadBatch(1);
        runBatch(1);
        openTest();
        checkResults(1, 0, 5);
        closeTest("zero and one operands");
        openTest();
        checkResults(1, 0, 7);
        closeTest("second batch");

        assertFails = u_approxMul.u_mulCtrl.u_mulCtrlAsserts.failCount;
        $display("Tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 testsPassed, testsFailed, errorCount, assertFails);
        if (testsFailed == 0 && errorCount == 0 && assertFails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== approxMul.f ====
hw/approxMulPkg.sv
hw/mulCtrlIf.sv
hw/opMem.sv
hw/resMem.sv
hw/mulCtrl.sv
hw/mulDatapath.sv
hw/approxMul.sv
test/approxMul_asserts.sv
test/approxMulTb.sv

// ==== Bender.yml ====
package:
  name: approxmul

sources:
  - hw/approxMulPkg.sv
  - hw/mulCtrlIf.sv
  - hw/opMem.sv
  - hw/resMem.sv
  - hw/mulCtrl.sv
  - hw/mulDatapath.sv
  - hw/approxMul.sv
  - target: test
    files:
      - test/approxMul_asserts.sv
      - test/approxMulTb.sv

// ==== test/approxMul_cases.txt ====
// Columns: opA opB expected result, all hex. Lines 1-8 are batch 1, lines 9-16 batch 2.
// Expected is (P << 16) >> (s1 + s2), P the product of the normalized top bytes.
8000 8000 40000000
ffff ffff fe010000
c350 9abc 754e0000
0f00 3000 02d00000
4321 00ab 002cc100
0123 2000 00244000
7fff 0fff 07f00800
1234 5678 0616c000
0000 1234 00000000
abcd 0000 00000000
0000 0000 00000000
0001 8000 00008000
0001 0001 00000001
ffff 0001 0000ff00
0300 00c0 00024000
6000 e000 54000000
